/* logic/mem_op_pkg.sv */
`default_nettype none

package mem_op_pkg;

    localparam int data_wd    = 32;
    localparam int sram_depth = 256;
    localparam int sram_aw    = $clog2(sram_depth);

    typedef enum logic [3:0] {
        op_alu  = 4'd0,
        op_lb   = 4'd1,
        op_lbu  = 4'd2,
        op_lh   = 4'd3,
        op_lhu  = 4'd4,
        op_lw   = 4'd5,
        op_lwl  = 4'd6,
        op_lwr  = 4'd7,
        op_sb   = 4'd8,
        op_sh   = 4'd9,
        op_sw   = 4'd10,
        op_eret = 4'd11
    } mem_op_t;

endpackage

`default_nettype wire

/* logic/pipe_bus_pkg.sv */
`default_nettype none

package pipe_bus_pkg;

    // execute to memory layout from the msb down
    //   badvaddr[113:82] eret[81] excode[80:76] ex[75] res_from_mem[74]
    //   gr_we[73] op[72:69] dest[68:64] result[63:32] pc[31:0]
    localparam int es_ms_bus_wd = 32 + 1 + 5 + 1 + 1 + 1 + 4 + 5 + 32 + 32;

    // memory to write-back layout from the msb down
    //   badvaddr[111:80] eret[79] excode[78:74] ex[73] rf_we[72:69]
    //   dest[68:64] result[63:32] pc[31:0]
    localparam int ms_ws_bus_wd = 32 + 1 + 5 + 1 + 4 + 5 + 32 + 32;

    typedef logic [es_ms_bus_wd-1:0] es_ms_bus_t;
    typedef logic [ms_ws_bus_wd-1:0] ms_ws_bus_t;

    // cause codes
    localparam logic [4:0] exc_adel = 5'd4;
    localparam logic [4:0] exc_ades = 5'd5;

    localparam logic [31:0] exc_vector = 32'hbfc0_0380;

endpackage

`default_nettype wire

/* logic/stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           in_valid,
    input  wire payload_t in_bus,
    input  wire           next_allowin,
    input  wire           flush,
    output logic          allowin,
    output logic          valid,
    output payload_t      bus
);

    // stage never stalls on its own
    assign allowin = !valid || next_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            bus <= in_bus;
        end
    end

    a_bus_known: assert property (
        @(posedge clk) disable iff (reset)
        valid |-> !$isunknown(bus)
    );

endmodule

`default_nettype wire

/* logic/exe_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module exe_stage (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             in_valid,
    input  wire mem_op_pkg::mem_op_t        in_op,
    input  wire [mem_op_pkg::data_wd-1:0]   in_pc,
    input  wire [mem_op_pkg::data_wd-1:0]   in_base,
    input  wire [mem_op_pkg::data_wd-1:0]   in_offset,
    input  wire [mem_op_pkg::data_wd-1:0]   in_store_data,
    input  wire [4:0]                       in_dest,
    input  wire                             ms_allowin,
    input  wire                             ms_flush,
    input  wire                             flush,
    output logic                            in_allowin,
    output logic                            es_to_ms_valid,
    output pipe_bus_pkg::es_ms_bus_t        es_to_ms_bus,
    output logic                            sram_en,
    output logic [3:0]                      sram_we,
    output logic [mem_op_pkg::sram_aw-1:0]  sram_addr,
    output logic [mem_op_pkg::data_wd-1:0]  sram_wdata
);
    import mem_op_pkg::*;
    import pipe_bus_pkg::*;

    typedef struct packed {
        mem_op_t            op;
        logic [data_wd-1:0] pc;
        logic [data_wd-1:0] base;
        logic [data_wd-1:0] offset;
        logic [data_wd-1:0] store_data;
        logic [4:0]         dest;
    } issue_t;

    issue_t             issue_in;
    issue_t             es;
    logic               es_valid;
    logic               es_allowin;
    logic [data_wd-1:0] addr;
    logic               is_load;
    logic               is_store;
    logic               adel;
    logic               ades;
    logic               es_ex;
    logic [4:0]         es_excode;
    logic               store_ok;
    logic [3:0]         lane_we;
    logic [data_wd-1:0] lane_data;

    assign issue_in = {in_op, in_pc, in_base, in_offset, in_store_data, in_dest};

    stage_reg #(.payload_t(issue_t)) es_reg_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_bus      (issue_in),
        .next_allowin(ms_allowin),
        .flush       (flush),
        .allowin     (es_allowin),
        .valid       (es_valid),
        .bus         (es)
    );

    // no new issue while the pipe is being flushed
    assign in_allowin = es_allowin && !flush;

    assign addr     = es.base + es.offset;
    assign is_load  = es.op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr};
    assign is_store = es.op inside {op_sb, op_sh, op_sw};

    // lwl/lwr and byte ops can't fault
    assign adel = (es.op inside {op_lh, op_lhu} && addr[0])
               || (es.op == op_lw && addr[1:0] != 2'b00);
    assign ades = (es.op == op_sh && addr[0])
               || (es.op == op_sw && addr[1:0] != 2'b00);
    assign es_ex     = adel || ades;
    assign es_excode = adel ? exc_adel : ades ? exc_ades : 5'd0;

    always_comb begin
        case (es.op)
            op_sb: begin
                lane_we   = 4'b0001 << addr[1:0];
                lane_data = {4{es.store_data[7:0]}};
            end
            op_sh: begin
                lane_we   = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{es.store_data[15:0]}};
            end
            default: begin
                lane_we   = 4'b1111;
                lane_data = es.store_data;
            end
        endcase
    end

    // older ex/eret in mem or wb kills this store
    assign store_ok   = es_valid && is_store && !es_ex && !ms_flush && !flush;
    assign sram_en    = (es_valid && is_load) || store_ok;
    assign sram_we    = store_ok ? lane_we : 4'b0000;
    assign sram_addr  = addr[sram_aw+1:2];
    assign sram_wdata = lane_data;

    assign es_to_ms_valid = es_valid;
    assign es_to_ms_bus   = {
        addr,
        es.op == op_eret,
        es_excode,
        es_ex,
        is_load,
        is_load || es.op == op_alu,
        es.op,
        es.dest,
        addr,
        es.pc
    };

endmodule

`default_nettype wire

/* logic/data_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_sram (
    input  wire                             clk,
    input  wire                             en,
    input  wire [3:0]                       we,
    input  wire [mem_op_pkg::sram_aw-1:0]   addr,
    input  wire [mem_op_pkg::data_wd-1:0]   wdata,
    output logic [mem_op_pkg::data_wd-1:0]  rdata
);
    import mem_op_pkg::*;

    logic [data_wd-1:0] mem [sram_depth];

    // read-before-write on the same word
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    a_we_needs_en: assert property (
        @(posedge clk) (we != 4'b0000) |-> en
    );

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             ws_allowin,
    input  wire                             es_to_ms_valid,
    input  wire pipe_bus_pkg::es_ms_bus_t   es_to_ms_bus,
    input  wire [mem_op_pkg::data_wd-1:0]   data_sram_rdata,
    input  wire                             flush,
    output logic                            ms_allowin,
    output logic                            ms_to_ws_valid,
    output pipe_bus_pkg::ms_ws_bus_t        ms_to_ws_bus,
    output logic                            fwd_valid,
    output logic [3:0]                      fwd_rf_we,
    output logic [4:0]                      fwd_dest,
    output logic [mem_op_pkg::data_wd-1:0]  fwd_data,
    output logic                            ms_flush
);
    import mem_op_pkg::*;
    import pipe_bus_pkg::*;

    es_ms_bus_t         ms_bus;
    logic               ms_valid;
    logic [data_wd-1:0] ms_badvaddr;
    logic               ms_eret;
    logic [4:0]         ms_excode;
    logic               ms_ex;
    logic               ms_res_from_mem;
    logic               ms_gr_we;
    logic [3:0]         ms_op_bits;
    logic [4:0]         ms_dest;
    logic [data_wd-1:0] ms_result;
    logic [data_wd-1:0] ms_pc;
    mem_op_t            ms_op;
    logic [1:0]         pos;
    logic [7:0]         lb_data;
    logic [15:0]        lh_data;
    logic [data_wd-1:0] mem_result;
    logic [data_wd-1:0] final_result;
    logic [3:0]         ms_rf_we;

    stage_reg #(.payload_t(es_ms_bus_t)) ms_reg_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (es_to_ms_valid),
        .in_bus      (es_to_ms_bus),
        .next_allowin(ws_allowin),
        .flush       (flush),
        .allowin     (ms_allowin),
        .valid       (ms_valid),
        .bus         (ms_bus)
    );

    assign {
        ms_badvaddr,
        ms_eret,
        ms_excode,
        ms_ex,
        ms_res_from_mem,
        ms_gr_we,
        ms_op_bits,
        ms_dest,
        ms_result,
        ms_pc
    } = ms_bus;

    assign ms_op = mem_op_t'(ms_op_bits);
    assign pos   = ms_result[1:0];

    assign lb_data = data_sram_rdata[{pos, 3'b000} +: 8];
    assign lh_data = pos[1] ? data_sram_rdata[31:16] : data_sram_rdata[15:0];

    always_comb begin
        case (ms_op)
            op_lb:   mem_result = {{24{lb_data[7]}}, lb_data};
            op_lbu:  mem_result = {24'b0, lb_data};
            op_lh:   mem_result = {{16{lh_data[15]}}, lh_data};
            op_lhu:  mem_result = {16'b0, lh_data};
            // lwl fills from the top, lwr from the bottom
            op_lwl:  mem_result = data_sram_rdata << {~pos, 3'b000};
            op_lwr:  mem_result = data_sram_rdata >> {pos, 3'b000};
            default: mem_result = data_sram_rdata;
        endcase
    end

    assign final_result = ms_res_from_mem ? mem_result : ms_result;

    // partial byte writes for the unaligned pair
    always_comb begin
        if (!ms_valid || ms_ex) begin
            ms_rf_we = 4'b0000;
        end else if (ms_op == op_lwl) begin
            ms_rf_we = {1'b1, pos != 2'd0, pos[1], pos == 2'd3};
        end else if (ms_op == op_lwr) begin
            ms_rf_we = {pos == 2'd0, ~pos[1], pos != 2'd3, 1'b1};
        end else begin
            ms_rf_we = {4{ms_gr_we}};
        end
    end

    assign ms_flush = ms_valid && (ms_ex || ms_eret);

    assign fwd_valid = ms_valid && ms_gr_we && !ms_ex;
    assign fwd_rf_we = ms_rf_we;
    assign fwd_dest  = ms_dest;
    assign fwd_data  = final_result;

    assign ms_to_ws_valid = ms_valid;
    assign ms_to_ws_bus   = {
        ms_badvaddr,
        ms_eret,
        ms_excode,
        ms_ex,
        ms_rf_we,
        ms_dest,
        final_result,
        ms_pc
    };

    a_fwd_idle: assert property (
        @(posedge clk) disable iff (reset)
        !ms_valid |-> fwd_rf_we == 4'b0000
    );

endmodule

`default_nettype wire

/* logic/wb_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             ms_to_ws_valid,
    input  wire pipe_bus_pkg::ms_ws_bus_t   ms_to_ws_bus,
    output logic                            ws_allowin,
    output logic [3:0]                      rf_we,
    output logic [4:0]                      rf_dest,
    output logic [mem_op_pkg::data_wd-1:0]  rf_wdata,
    output logic                            flush,
    output logic [mem_op_pkg::data_wd-1:0]  redirect_pc,
    output logic [4:0]                      exc_code,
    output logic [mem_op_pkg::data_wd-1:0]  badvaddr
);
    import mem_op_pkg::*;
    import pipe_bus_pkg::*;

    ms_ws_bus_t         ws_bus;
    logic               ws_valid;
    logic [data_wd-1:0] ws_badvaddr;
    logic               ws_eret;
    logic [4:0]         ws_excode;
    logic               ws_ex;
    logic [3:0]         ws_rf_we;
    logic [data_wd-1:0] ws_pc;
    logic               ex_commit;
    logic [data_wd-1:0] epc;
    logic [4:0]         cause;
    logic [data_wd-1:0] badvaddr_r;

    stage_reg #(.payload_t(ms_ws_bus_t)) ws_reg_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (ms_to_ws_valid),
        .in_bus      (ms_to_ws_bus),
        .next_allowin(1'b1),
        .flush       (flush),
        .allowin     (ws_allowin),
        .valid       (ws_valid),
        .bus         (ws_bus)
    );

    assign {ws_badvaddr, ws_eret, ws_excode, ws_ex, ws_rf_we, rf_dest, rf_wdata, ws_pc} = ws_bus;

    assign ex_commit = ws_valid && ws_ex;
    assign rf_we     = (ws_valid && !ws_ex) ? ws_rf_we : 4'b0000;
    assign flush     = ws_valid && (ws_ex || ws_eret);

    // minimal cp0 with epc, cause code and badvaddr
    always_ff @(posedge clk) begin
        if (reset) begin
            epc        <= '0;
            cause      <= 5'd0;
            badvaddr_r <= '0;
        end else if (ex_commit) begin
            epc        <= ws_pc;
            cause      <= ws_excode;
            badvaddr_r <= ws_badvaddr;
        end
    end

    assign redirect_pc = ws_ex ? exc_vector : epc;
    assign exc_code    = ex_commit ? ws_excode : cause;
    assign badvaddr    = ex_commit ? ws_badvaddr : badvaddr_r;

    a_flush_single: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !flush
    );

endmodule

`default_nettype wire

/* logic/mem_pipe_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_pipe_top (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             in_valid,
    input  wire mem_op_pkg::mem_op_t        in_op,
    input  wire [mem_op_pkg::data_wd-1:0]   in_pc,
    input  wire [mem_op_pkg::data_wd-1:0]   in_base,
    input  wire [mem_op_pkg::data_wd-1:0]   in_offset,
    input  wire [mem_op_pkg::data_wd-1:0]   in_store_data,
    input  wire [4:0]                       in_dest,
    output logic                            in_allowin,
    output logic [3:0]                      rf_we,
    output logic [4:0]                      rf_dest,
    output logic [mem_op_pkg::data_wd-1:0]  rf_wdata,
    output logic                            fwd_valid,
    output logic [3:0]                      fwd_rf_we,
    output logic [4:0]                      fwd_dest,
    output logic [mem_op_pkg::data_wd-1:0]  fwd_data,
    output logic                            flush,
    output logic [mem_op_pkg::data_wd-1:0]  redirect_pc,
    output logic [4:0]                      exc_code,
    output logic [mem_op_pkg::data_wd-1:0]  badvaddr
);
    import mem_op_pkg::*;
    import pipe_bus_pkg::*;

    logic               es_to_ms_valid;
    es_ms_bus_t         es_to_ms_bus;
    logic               ms_allowin;
    logic               ms_flush;
    logic               ms_to_ws_valid;
    ms_ws_bus_t         ms_to_ws_bus;
    logic               ws_allowin;
    logic               sram_en;
    logic [3:0]         sram_we;
    logic [sram_aw-1:0] sram_addr;
    logic [data_wd-1:0] sram_wdata;
    logic [data_wd-1:0] sram_rdata;

    exe_stage exe_stage_i (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_op(in_op), .in_pc(in_pc),
        .in_base(in_base), .in_offset(in_offset),
        .in_store_data(in_store_data), .in_dest(in_dest),
        .ms_allowin(ms_allowin), .ms_flush(ms_flush), .flush(flush),
        .in_allowin(in_allowin),
        .es_to_ms_valid(es_to_ms_valid), .es_to_ms_bus(es_to_ms_bus),
        .sram_en(sram_en), .sram_we(sram_we),
        .sram_addr(sram_addr), .sram_wdata(sram_wdata)
    );

    data_sram data_sram_i (
        .clk(clk), .en(sram_en), .we(sram_we),
        .addr(sram_addr), .wdata(sram_wdata), .rdata(sram_rdata)
    );

    mem_stage mem_stage_i (
        .clk(clk), .reset(reset), .ws_allowin(ws_allowin),
        .es_to_ms_valid(es_to_ms_valid), .es_to_ms_bus(es_to_ms_bus),
        .data_sram_rdata(sram_rdata), .flush(flush),
        .ms_allowin(ms_allowin),
        .ms_to_ws_valid(ms_to_ws_valid), .ms_to_ws_bus(ms_to_ws_bus),
        .fwd_valid(fwd_valid), .fwd_rf_we(fwd_rf_we),
        .fwd_dest(fwd_dest), .fwd_data(fwd_data), .ms_flush(ms_flush)
    );

    wb_stage wb_stage_i (
        .clk(clk), .reset(reset),
        .ms_to_ws_valid(ms_to_ws_valid), .ms_to_ws_bus(ms_to_ws_bus),
        .ws_allowin(ws_allowin),
        .rf_we(rf_we), .rf_dest(rf_dest), .rf_wdata(rf_wdata),
        .flush(flush), .redirect_pc(redirect_pc),
        .exc_code(exc_code), .badvaddr(badvaddr)
    );

endmodule

`default_nettype wire

/* dv/mem_pipe_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_pipe_tb;
    import mem_op_pkg::*;

    localparam int          max_tests     = 64;
    localparam int          cols          = 9;
    localparam int          col_name      = 0;
    localparam int          col_op        = 1;
    localparam int          col_base      = 2;
    localparam int          col_offset    = 3;
    localparam int          col_sdata     = 4;
    localparam int          col_dest      = 5;
    localparam int          col_we        = 6;
    localparam int          col_wdata     = 7;
    localparam int          col_excode    = 8;
    localparam logic [31:0] end_mark      = 32'hffff_ffff;
    localparam logic [31:0] exc_vector_pc = 32'hbfc0_0380;
    localparam logic [31:0] pc_base       = 32'hbfc0_0000;

    logic        clk;
    logic        reset;
    logic        in_valid;
    mem_op_t     in_op;
    logic [31:0] in_pc;
    logic [31:0] in_base;
    logic [31:0] in_offset;
    logic [31:0] in_store_data;
    logic [4:0]  in_dest;
    logic        in_allowin;
    logic [3:0]  rf_we;
    logic [4:0]  rf_dest;
    logic [31:0] rf_wdata;
    logic        fwd_valid;
    logic [3:0]  fwd_rf_we;
    logic [4:0]  fwd_dest;
    logic [31:0] fwd_data;
    logic        flush;
    logic [31:0] redirect_pc;
    logic [4:0]  exc_code;
    logic [31:0] badvaddr;

    logic [31:0] tv [cols*max_tests];
    int          num_tests;
    int          exp_q [$];
    logic        pending_flush;
    logic [31:0] last_epc;
    logic        prev_fwd_valid;
    logic [3:0]  prev_fwd_rf_we;
    logic [4:0]  prev_fwd_dest;
    logic [31:0] prev_fwd_data;

    mem_pipe_top dut_i (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_op(in_op), .in_pc(in_pc),
        .in_base(in_base), .in_offset(in_offset),
        .in_store_data(in_store_data), .in_dest(in_dest),
        .in_allowin(in_allowin),
        .rf_we(rf_we), .rf_dest(rf_dest), .rf_wdata(rf_wdata),
        .fwd_valid(fwd_valid), .fwd_rf_we(fwd_rf_we),
        .fwd_dest(fwd_dest), .fwd_data(fwd_data),
        .flush(flush), .redirect_pc(redirect_pc),
        .exc_code(exc_code), .badvaddr(badvaddr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    function automatic logic [31:0] pc_of(input int t);
        return pc_base + 32'(t) * 32'd4;
    endfunction

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic give_up(input string reason);
        $display("ERROR: %s", reason);
        stop_run();
    endtask

    task automatic compare(input logic [31:0] name, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] test %02h %s expected %08h actual %08h",
                     name, what, expected, actual);
            stop_run();
        end
    endtask

    task automatic drive_test(input int t);
        in_valid      = 1'b1;
        in_op         = mem_op_t'(tv[t*cols + col_op][3:0]);
        in_pc         = pc_of(t);
        in_base       = tv[t*cols + col_base];
        in_offset     = tv[t*cols + col_offset];
        in_store_data = tv[t*cols + col_sdata];
        in_dest       = tv[t*cols + col_dest][4:0];
    endtask

    // anything taken in while a fault or eret is in flight dies
    task automatic accept_test(input int t);
        logic flusher;
        flusher = tv[t*cols + col_excode] != 32'd0 || tv[t*cols + col_op][3:0] == op_eret;
        if (!pending_flush) begin
            if (flusher || tv[t*cols + col_we] != 32'd0) begin
                exp_q.push_back(t);
            end
            if (flusher) begin
                pending_flush = 1'b1;
            end
        end
    endtask

    task automatic check_outputs();
        int          t;
        logic [31:0] name;
        logic        is_ex;
        logic        flusher;
        if (rf_we != 4'b0000 || flush) begin
            if (exp_q.size() == 0) begin
                give_up("register write or flush seen with no instruction left to retire");
            end else begin
                t       = exp_q.pop_front();
                name    = tv[t*cols + col_name];
                is_ex   = tv[t*cols + col_excode] != 32'd0;
                flusher = is_ex || tv[t*cols + col_op][3:0] == op_eret;
                compare(name, "rf_we", tv[t*cols + col_we], 32'(rf_we));
                compare(name, "flush", 32'(flusher), 32'(flush));
                if (rf_we != 4'b0000) begin
                    compare(name, "rf_dest", tv[t*cols + col_dest], 32'(rf_dest));
                    compare(name, "rf_wdata", tv[t*cols + col_wdata], rf_wdata);
                    // same instruction sat in mem one cycle earlier
                    compare(name, "fwd_valid", 32'd1, 32'(prev_fwd_valid));
                    compare(name, "fwd_rf_we", tv[t*cols + col_we], 32'(prev_fwd_rf_we));
                    compare(name, "fwd_dest", tv[t*cols + col_dest], 32'(prev_fwd_dest));
                    compare(name, "fwd_data", tv[t*cols + col_wdata], prev_fwd_data);
                end
                if (flush) begin
                    if (is_ex) begin
                        compare(name, "redirect_pc", exc_vector_pc, redirect_pc);
                        compare(name, "exc_code", tv[t*cols + col_excode], 32'(exc_code));
                        compare(name, "badvaddr",
                                tv[t*cols + col_base] + tv[t*cols + col_offset], badvaddr);
                        last_epc = pc_of(t);
                    end else begin
                        compare(name, "redirect_pc", last_epc, redirect_pc);
                    end
                    pending_flush = 1'b0;
                end
            end
        end
    endtask

    initial begin
        int         cycles;
        int         limit;
        int         drain;
        int         next_test;
        logic       presenting;
        logic       decided;
        logic       skip;
        logic [7:0] lfsr;

        reset          = 1'b1;
        in_valid       = 1'b0;
        in_op          = op_alu;
        in_pc          = '0;
        in_base        = '0;
        in_offset      = '0;
        in_store_data  = '0;
        in_dest        = '0;
        pending_flush  = 1'b0;
        last_epc       = '0;
        prev_fwd_valid = 1'b0;
        prev_fwd_rf_we = '0;
        prev_fwd_dest  = '0;
        prev_fwd_data  = '0;

        $readmemh("dv/mem_pipe_tests.txt", tv);
        num_tests = 0;
        while (num_tests < max_tests && tv[num_tests*cols + col_name] != end_mark) begin
            num_tests++;
        end
        if (num_tests == 0 || num_tests == max_tests) begin
            give_up("test file is empty or has no end marker");
        end
        limit = 5 * num_tests + 100;

        lfsr       = 8'd93;
        cycles     = 0;
        drain      = 0;
        next_test  = 0;
        presenting = 1'b0;
        decided    = 1'b0;

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        while (drain < 8) begin
            @(posedge clk);
            #2;
            // a held instruction stays on the port until taken
            if (!presenting) begin
                skip = 1'b1;
                if (next_test < num_tests) begin
                    if (!decided) begin
                        lfsr    = lfsr_step(lfsr);
                        decided = 1'b1;
                        skip    = lfsr[0];
                    end else begin
                        skip = 1'b0;
                    end
                end
                if (skip) begin
                    in_valid = 1'b0;
                end else begin
                    drive_test(next_test);
                    presenting = 1'b1;
                end
            end

            @(negedge clk);
            check_outputs();
            prev_fwd_valid = fwd_valid;
            prev_fwd_rf_we = fwd_rf_we;
            prev_fwd_dest  = fwd_dest;
            prev_fwd_data  = fwd_data;
            if (in_valid && in_allowin) begin
                accept_test(next_test);
                next_test++;
                presenting = 1'b0;
                decided    = 1'b0;
            end

            cycles++;
            if (cycles >= limit) begin
                give_up($sformatf("timeout after %0d cycles with %0d of %0d tests issued",
                                  cycles, next_test, num_tests));
            end
            if (next_test == num_tests && exp_q.size() == 0) begin
                drain++;
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/mem_pipe_tests.txt */
// name op base offset store_data dest rf_we rf_wdata excode, nine hex words per line
// op 0 alu 1 lb 2 lbu 3 lh 4 lhu 5 lw 6 lwl 7 lwr 8 sb 9 sh a sw b eret; ffffffff ends the list
01 a 00000100 00000000 8badf00d 00 0 00000000 00
02 8 00000100 00000001 000000c5 00 0 00000000 00
03 9 00000100 00000002 00007f31 00 0 00000000 00
04 5 00000100 00000000 00000000 01 f 7f31c50d 00
05 1 00000100 00000000 00000000 02 f 0000000d 00
06 1 00000100 00000001 00000000 03 f ffffffc5 00
07 2 00000100 00000001 00000000 04 f 000000c5 00
08 1 00000110 fffffff2 00000000 05 f 00000031 00
09 2 000000fe 00000005 00000000 06 f 0000007f 00
0a 3 00000100 00000000 00000000 07 f ffffc50d 00
0b 4 00000100 00000000 00000000 08 f 0000c50d 00
0c 3 000000fe 00000004 00000000 09 f 00007f31 00
0d 4 00000102 00000000 00000000 0a f 00007f31 00
0e a 00000200 00000000 44332211 00 0 00000000 00
0f 6 00000200 00000000 00000000 10 8 11000000 00
10 6 00000200 00000001 00000000 10 c 22110000 00
11 6 00000200 00000002 00000000 10 e 33221100 00
12 6 00000200 00000003 00000000 10 f 44332211 00
13 7 00000200 00000000 00000000 10 f 44332211 00
14 7 00000200 00000001 00000000 10 7 00443322 00
15 7 00000200 00000002 00000000 10 3 00004433 00
16 7 00000200 00000003 00000000 10 1 00000044 00
17 0 12345678 11111111 00000000 11 f 23456789 00
18 3 00000100 00000001 00000000 12 0 00000000 04
19 a 00000100 00000000 deadbeef 00 0 00000000 00
1a 0 00000001 00000002 00000000 13 f 00000003 00
1b 9 000000fc 00000007 0000aaaa 00 0 00000000 05
1c 8 00000100 00000000 00000055 00 0 00000000 00
1d 0 00000010 00000020 00000000 14 f 00000030 00
1e a 00000200 00000006 99999999 00 0 00000000 05
1f a 00000200 00000000 00000000 00 0 00000000 00
20 0 00000100 00000200 00000000 15 f 00000300 00
21 5 00000100 00000002 00000000 16 0 00000000 04
22 8 00000200 00000003 000000ee 00 0 00000000 00
23 0 fffffff0 00000010 00000000 17 f 00000000 00
24 5 00000100 00000000 00000000 18 f 7f31c50d 00
25 5 00000200 00000000 00000000 19 f 44332211 00
26 b 00000000 00000000 00000000 00 0 00000000 00
27 0 00000001 00000001 00000000 1a f 00000002 00
28 0 7fffffff 00000001 00000000 1b f 80000000 00
ffffffff 0 00000000 00000000 00000000 00 0 00000000 00

/* list.f */
logic/mem_op_pkg.sv
logic/pipe_bus_pkg.sv
logic/stage_reg.sv
logic/exe_stage.sv
logic/data_sram.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/mem_pipe_top.sv
dv/mem_pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module mem_pipe_tb -f list.f -o mem_pipe_sim

./obj_dir/mem_pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -qxF '** PASS **' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
